// File: run.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module lidar_tb -f sim.f &&
./obj_dir/Vlidar_tb > sim.log 2>&1 ||
echo "build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -q "^Regression passed$" sim.log && exit 0 || exit 1

// File: sim.f
src/lidar_pkg.sv
src/tdc_spi_master.sv
src/tdc_shot_control.sv
src/sample_fifo.sv
src/uart_word_tx.sv
src/lidar_top.sv
verif/lidar_props.sv
verif/lidar_tb.sv

// File: src/lidar_pkg.sv
`default_nettype none

package lidar_pkg;

  // raw time word from the tdc result register
  typedef logic [15:0] tdc_result_t;

  // running shot number, wraps at 16 bits
  typedef logic [15:0] shot_id_t;

  // one byte on the tdc spi or on the uart
  typedef logic [7:0] spi_byte_t;

  // one fifo entry
  // shot number on top so it leaves the uart first
  typedef struct packed {
    shot_id_t    shot;
    tdc_result_t result;
  } sample_t;

  // opcode that reads back the result register
  localparam spi_byte_t TDC_READ_OP = 8'hB0;

  // uart frames per sample
  localparam int SAMPLE_BYTES = $bits(sample_t) / $bits(spi_byte_t);

endpackage

`default_nettype wire

// File: src/lidar_top.sv
`default_nettype none

module lidar_top import lidar_pkg::*; #(
  // 50 MHz clock, 12 kHz shots
  parameter int SHOT_DIV = 4166,
  // 6.25 MHz sck
  parameter int SPI_DIV  = 4,
  // 4 Mbaud
  parameter int BAUD_DIV = 12,
  parameter int FIFO_AW  = 6
) (
  input  logic clk,
  input  logic rst_n,
  input  logic pause,
  input  logic tdc_intb,
  input  logic tdc_miso,
  output logic tdc_start_signal,
  output logic tdc_sck,
  output logic tdc_mosi,
  output logic tdc_cs,
  output logic serial_out
);

  // controller to spi master
  logic      spi_start;
  logic      spi_busy;
  logic      spi_cs_end;
  spi_byte_t spi_tx_byte;
  spi_byte_t spi_rx_byte;

  // fifo handshake
  logic      wr_en;
  logic      rd_en;
  logic      full;
  logic      empty;
  sample_t   din;
  sample_t   dout;

  tdc_shot_control #(.SHOT_DIV(SHOT_DIV)) tdc_shot_control (
    .clk(clk),
    .rst_n(rst_n),
    .pause(pause),
    .tdc_intb(tdc_intb),
    .spi_busy(spi_busy),
    .spi_rx_byte(spi_rx_byte),
    .full(full),
    .tdc_start_signal(tdc_start_signal),
    .spi_start(spi_start),
    .spi_tx_byte(spi_tx_byte),
    .spi_cs_end(spi_cs_end),
    .wr_en(wr_en),
    .din(din)
  );

  tdc_spi_master #(.SPI_DIV(SPI_DIV)) tdc_spi_master (
    .clk(clk),
    .rst_n(rst_n),
    .start(spi_start),
    .tx_byte(spi_tx_byte),
    .cs_end(spi_cs_end),
    .tdc_miso(tdc_miso),
    .busy(spi_busy),
    .rx_byte(spi_rx_byte),
    .tdc_sck(tdc_sck),
    .tdc_mosi(tdc_mosi),
    .tdc_cs(tdc_cs)
  );

  sample_fifo #(.FIFO_AW(FIFO_AW)) sample_fifo (
    .clk(clk),
    .rst_n(rst_n),
    .wr_en(wr_en),
    .din(din),
    .rd_en(rd_en),
    .dout(dout),
    .full(full),
    .empty(empty)
  );

  uart_word_tx #(.BAUD_DIV(BAUD_DIV)) uart_word_tx (
    .clk(clk),
    .rst_n(rst_n),
    .dout(dout),
    .empty(empty),
    .rd_en(rd_en),
    .serial_out(serial_out)
  );

endmodule

`default_nettype wire

// File: src/sample_fifo.sv
`default_nettype none

module sample_fifo import lidar_pkg::*; #(
  parameter int FIFO_AW = 6
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    wr_en,
  input  sample_t din,
  input  logic    rd_en,
  output sample_t dout,
  output logic    full,
  output logic    empty
);

  localparam int DEPTH = 2 ** FIFO_AW;

  sample_t            mem [DEPTH];
  // extra top bit tells full from empty
  logic [FIFO_AW:0]   wr_ptr;
  logic [FIFO_AW:0]   rd_ptr;
  logic [FIFO_AW-1:0] wr_idx;
  logic [FIFO_AW-1:0] rd_idx;

  assign wr_idx = wr_ptr[FIFO_AW-1:0];
  assign rd_idx = rd_ptr[FIFO_AW-1:0];

  // storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // head shown ahead of the pop
  assign dout = mem[rd_idx];

  // same index, wrap bits tell the two apart
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) && (wr_idx == rd_idx);

endmodule

`default_nettype wire

// File: src/tdc_shot_control.sv
`default_nettype none

module tdc_shot_control import lidar_pkg::*; #(
  parameter int SHOT_DIV = 4166
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      pause,
  input  logic      tdc_intb,
  input  logic      spi_busy,
  input  spi_byte_t spi_rx_byte,
  input  logic      full,
  output logic      tdc_start_signal,
  output logic      spi_start,
  output spi_byte_t spi_tx_byte,
  output logic      spi_cs_end,
  output logic      wr_en,
  output sample_t   din
);

  // shot timer width, at least one bit
  localparam int SHOT_W = (SHOT_DIV > 1) ? $clog2(SHOT_DIV) : 1;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SHOT,
    ST_WAIT_INT,
    ST_OP,
    ST_RD_HI,
    ST_RD_LO,
    ST_WRITE
  } state_t;

  state_t            state;
  logic [SHOT_W-1:0] shot_cnt;
  shot_id_t          shot_id;
  tdc_result_t       result;
  // interrupt comes from the tdc clock domain
  logic [1:0]        intb_sync;
  // byte handed to the spi master, not finished yet
  logic              spi_pending;
  logic              spi_state;
  logic              spi_done;

  assign spi_state = (state == ST_OP) || (state == ST_RD_HI) || (state == ST_RD_LO);

  // start is still up the cycle after issue, busy covers the rest
  assign spi_done = spi_pending && !spi_start && !spi_busy;

  // full fifo parks the sample here
  assign wr_en = (state == ST_WRITE) && !full;
  assign din   = '{shot: shot_id, result: result};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      intb_sync <= 2'b11;
    end else begin
      intb_sync <= {intb_sync[0], tdc_intb};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state            <= ST_IDLE;
      shot_cnt         <= '0;
      shot_id          <= '0;
      tdc_start_signal <= 1'b0;
      spi_start        <= 1'b0;
      spi_tx_byte      <= '0;
      spi_cs_end       <= 1'b0;
      spi_pending      <= 1'b0;
    end else begin
      // strobes last one cycle
      tdc_start_signal <= 1'b0;
      spi_start        <= 1'b0;

      // shared byte issue for opcode and both reads
      if (spi_state && !spi_pending && !spi_busy) begin
        spi_start   <= 1'b1;
        spi_pending <= 1'b1;
        spi_tx_byte <= (state == ST_OP) ? TDC_READ_OP : spi_byte_t'(0);
        // only the low result byte closes the transaction
        spi_cs_end  <= (state == ST_RD_LO);
      end

      case (state)
        ST_IDLE: begin
          // pause freezes the timer, nothing else
          if (!pause) begin
            if (shot_cnt == SHOT_W'(SHOT_DIV - 1)) begin
              shot_cnt         <= '0;
              tdc_start_signal <= 1'b1;
              state            <= ST_SHOT;
            end else begin
              shot_cnt <= shot_cnt + 1'b1;
            end
          end
        end
        ST_SHOT: begin
          state <= ST_WAIT_INT;
        end
        ST_WAIT_INT: begin
          // intb low means the measurement is ready
          if (!intb_sync[1]) begin
            state <= ST_OP;
          end
        end
        ST_OP: begin
          if (spi_done) begin
            spi_pending <= 1'b0;
            state       <= ST_RD_HI;
          end
        end
        ST_RD_HI: begin
          if (spi_done) begin
            spi_pending <= 1'b0;
            state       <= ST_RD_LO;
          end
        end
        ST_RD_LO: begin
          if (spi_done) begin
            spi_pending <= 1'b0;
            state       <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (!full) begin
            shot_id  <= shot_id + 1'b1;
            shot_cnt <= '0;
            state    <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // result bytes, high byte read first
  always_ff @(posedge clk) begin
    if (spi_done && (state == ST_RD_HI)) begin
      result[15:8] <= spi_rx_byte;
    end
    if (spi_done && (state == ST_RD_LO)) begin
      result[7:0] <= spi_rx_byte;
    end
  end

endmodule

`default_nettype wire

// File: src/tdc_spi_master.sv
`default_nettype none

module tdc_spi_master import lidar_pkg::*; #(
  parameter int SPI_DIV = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  spi_byte_t tx_byte,
  input  logic      cs_end,
  input  logic      tdc_miso,
  output logic      busy,
  output spi_byte_t rx_byte,
  output logic      tdc_sck,
  output logic      tdc_mosi,
  output logic      tdc_cs
);

  // half period counter, at least one bit wide
  localparam int DIV_W = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;
  // sck edges within the byte, 16 per byte
  logic [3:0]       edge_cnt;
  spi_byte_t        tx_shift;
  // release chip select after this byte
  logic             cs_end_q;
  logic             half_done;

  assign half_done = (div_cnt == DIV_W'(SPI_DIV - 1));

  // mode 0, msb first
  assign tdc_mosi = tx_shift[7];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      div_cnt  <= '0;
      edge_cnt <= '0;
      tx_shift <= '0;
      cs_end_q <= 1'b0;
      tdc_sck  <= 1'b0;
      tdc_cs   <= 1'b1;
    end else if (!busy) begin
      div_cnt  <= '0;
      edge_cnt <= '0;
      if (start) begin
        busy     <= 1'b1;
        tx_shift <= tx_byte;
        cs_end_q <= cs_end;
        // select drops on the first byte, stays low between bytes
        tdc_cs   <= 1'b0;
      end
    end else if (half_done) begin
      div_cnt  <= '0;
      edge_cnt <= edge_cnt + 4'd1;
      tdc_sck  <= ~tdc_sck;
      if (tdc_sck) begin
        // falling edge, next bit onto mosi
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
      // last falling edge ends the byte, sck is back low
      if (edge_cnt == 4'd15) begin
        busy <= 1'b0;
        if (cs_end_q) begin
          tdc_cs <= 1'b1;
        end
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // receive shifter
  // miso taken on rising sck, complete when busy falls
  always_ff @(posedge clk) begin
    if (busy && half_done && !tdc_sck) begin
      rx_byte <= {rx_byte[6:0], tdc_miso};
    end
  end

endmodule

`default_nettype wire

// File: src/uart_word_tx.sv
`default_nettype none

module uart_word_tx import lidar_pkg::*; #(
  parameter int BAUD_DIV = 12
) (
  input  logic    clk,
  input  logic    rst_n,
  input  sample_t dout,
  input  logic    empty,
  output logic    rd_en,
  output logic    serial_out
);

  localparam int BAUD_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam int BYTE_W = (SAMPLE_BYTES > 1) ? $clog2(SAMPLE_BYTES) : 1;
  localparam int MSB    = $bits(sample_t) - 1;
  localparam int BW     = $bits(spi_byte_t);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_SEND
  } state_t;

  state_t            state;
  logic [BAUD_W-1:0] baud_cnt;
  // bit within the frame, start is 0, stop is 9
  logic [3:0]        bit_cnt;
  logic [BYTE_W-1:0] byte_cnt;
  // bytes still to go, next one on top
  sample_t           word;
  // stop, data lsb first, start
  logic [9:0]        frame;
  logic              baud_tick;

  assign baud_tick  = (baud_cnt == BAUD_W'(BAUD_DIV - 1));
  assign serial_out = frame[0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      rd_en    <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      byte_cnt <= '0;
      // line idles high
      frame    <= '1;
    end else begin
      case (state)
        ST_IDLE: begin
          if (!empty) begin
            rd_en <= 1'b1;
            state <= ST_LOAD;
          end
        end
        ST_LOAD: begin
          // head is still on dout while rd_en pops it
          rd_en    <= 1'b0;
          baud_cnt <= '0;
          bit_cnt  <= '0;
          byte_cnt <= '0;
          frame    <= {1'b1, dout[MSB -: BW], 1'b0};
          state    <= ST_SEND;
        end
        ST_SEND: begin
          if (!baud_tick) begin
            baud_cnt <= baud_cnt + 1'b1;
          end else begin
            baud_cnt <= '0;
            if (bit_cnt != 4'd9) begin
              bit_cnt <= bit_cnt + 4'd1;
              frame   <= {1'b1, frame[9:1]};
            end else if (byte_cnt == BYTE_W'(SAMPLE_BYTES - 1)) begin
              // last stop bit done
              frame <= '1;
              state <= ST_IDLE;
            end else begin
              bit_cnt  <= '0;
              byte_cnt <= byte_cnt + 1'b1;
              frame    <= {1'b1, word[MSB -: BW], 1'b0};
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // payload, shifted up one byte per frame
  always_ff @(posedge clk) begin
    if (state == ST_LOAD) begin
      word <= sample_t'({dout[MSB-BW:0], spi_byte_t'(0)});
    end else if (state == ST_SEND && baud_tick && bit_cnt == 4'd9) begin
      word <= sample_t'({word[MSB-BW:0], spi_byte_t'(0)});
    end
  end

endmodule

`default_nettype wire

// File: verif/lidar_props.sv
`default_nettype none

module lidar_props (
  input logic clk,
  input logic rst_n,
  // first request and the flag that must hold it off
  input logic req_a,
  input logic block_a,
  // second request and its hold off flag
  input logic req_b,
  input logic block_b,
  // strobe that must drop after one cycle
  input logic pulse
);

  timeunit 1ns;
  timeprecision 1ps;

  // read back by the testbench at the end
  int fail_count = 0;

  // producer holds its sample while the fifo is full
  req_a_held_off: assert property (@(posedge clk) disable iff (!rst_n)
    !(req_a && block_a))
    else begin
      fail_count++;
      $error("%m req_a high while block_a set");
    end

  // second request never issued while held off
  req_b_held_off: assert property (@(posedge clk) disable iff (!rst_n)
    !(req_b && block_b))
    else begin
      fail_count++;
      $error("%m req_b high while block_b set");
    end

  // single cycle strobe
  pulse_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    pulse |=> !pulse)
    else begin
      fail_count++;
      $error("%m pulse longer than one cycle");
    end

endmodule

// controller side
// fifo write against full, spi start against busy, tdc start strobe
bind tdc_shot_control lidar_props shot_props (
  .clk(clk),
  .rst_n(rst_n),
  .req_a(wr_en),
  .block_a(full),
  .req_b(spi_start),
  .block_b(spi_busy),
  .pulse(tdc_start_signal)
);

// fifo side
// write against full, pop against empty, pop lasts one cycle
bind sample_fifo lidar_props fifo_props (
  .clk(clk),
  .rst_n(rst_n),
  .req_a(wr_en),
  .block_a(full),
  .req_b(rd_en),
  .block_b(empty),
  .pulse(rd_en)
);

`default_nettype wire

// File: verif/lidar_tb.sv
`default_nettype none

module lidar_tb import lidar_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // uart far slower than the shot rate, tiny fifo
  localparam int SHOT_DIV     = 20;
  localparam int SPI_DIV      = 2;
  localparam int BAUD_DIV     = 16;
  localparam int FIFO_AW      = 2;
  localparam int NUM_SAMPLES  = 28;
  localparam int PAUSE_CYCLES = 4000;
  localparam int SEED         = 95062;
  localparam int TIMEOUT_CYCLES =
    2 * (NUM_SAMPLES * (40 * BAUD_DIV + SHOT_DIV) + PAUSE_CYCLES);

  logic clk;
  logic rst_n;
  logic pause;
  logic tdc_intb;
  logic tdc_miso;
  logic tdc_start_signal;
  logic tdc_sck;
  logic tdc_mosi;
  logic tdc_cs;
  logic serial_out;

  // one random result per shot, index is the shot number
  tdc_result_t shot_results[$];
  sample_t     rx_words[$];
  int n_words = 0;
  int n_xfers = 0;
  int n_starts = 0;
  int n_checks = 0;
  int errors = 0;
  int byte_errors = 0;
  int sample_errors = 0;
  bit saw_full = 1'b0;

  lidar_top #(
    .SHOT_DIV(SHOT_DIV),
    .SPI_DIV(SPI_DIV),
    .BAUD_DIV(BAUD_DIV),
    .FIFO_AW(FIFO_AW)
  ) DUT (
    .clk(clk),
    .rst_n(rst_n),
    .pause(pause),
    .tdc_intb(tdc_intb),
    .tdc_miso(tdc_miso),
    .tdc_start_signal(tdc_start_signal),
    .tdc_sck(tdc_sck),
    .tdc_mosi(tdc_mosi),
    .tdc_cs(tdc_cs),
    .serial_out(serial_out)
  );

  always #20 clk = ~clk;

  // shot number on top, tdc time below
  function automatic sample_t expected_sample(int idx, tdc_result_t res);
    sample_t s;
    s.shot   = shot_id_t'(idx);
    s.result = res;
    return s;
  endfunction

  task automatic note_failure(string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic check_sample(string name, sample_t got, sample_t exp);
    n_checks++;
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      errors++;
      sample_errors++;
    end
  endtask

  task automatic check_byte(string name, spi_byte_t got, spi_byte_t exp);
    n_checks++;
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      errors++;
      byte_errors++;
    end
  endtask

  task automatic check_level(string name, logic got, logic exp);
    n_checks++;
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(string name, bit ok);
    $display("test %s: %s", name, ok ? "ok" : "FAILED");
  endtask

  task automatic wait_words(int count);
    while (n_words < count) begin
      @(posedge clk);
    end
  endtask

  // start pulses and fifo full, taken mid cycle
  always @(negedge clk) begin
    if (tdc_start_signal) begin
      n_starts++;
    end
    if (DUT.full) begin
      saw_full = 1'b1;
    end
  end

  // tdc: random conversion time, intb low until the read starts
  initial begin : tdc_model
    int unsigned delay;
    void'($urandom(SEED));
    forever begin
      @(negedge clk);
      if (tdc_start_signal) begin
        shot_results.push_back(tdc_result_t'($urandom));
        delay = $urandom_range(40, 5);
        repeat (delay) @(posedge clk);
        #2;
        tdc_intb = 1'b0;
        do begin
          @(negedge clk);
        end while (tdc_cs !== 1'b0);
        @(posedge clk);
        #2;
        tdc_intb = 1'b1;
      end
    end
  end

  // spi slave, opcode byte then 16 result bits
  initial begin : spi_slave
    tdc_result_t res;
    logic [23:0] miso_bits;
    spi_byte_t   op_byte;
    forever begin
      @(negedge tdc_cs);
      res = (n_xfers < shot_results.size()) ? shot_results[n_xfers] : '0;
      miso_bits = {8'h00, res};
      op_byte = '0;
      #2;
      tdc_miso = miso_bits[23];
      for (int i = 0; i < 24; i++) begin
        // master samples on rising sck
        @(posedge tdc_sck);
        if (i < 8) begin
          op_byte = {op_byte[6:0], tdc_mosi};
        end
        @(negedge tdc_sck);
        #2;
        if (i < 23) begin
          tdc_miso = miso_bits[22 - i];
        end
      end
      check_byte("tdc_mosi", op_byte, TDC_READ_OP);
      n_xfers++;
    end
  end

  // uart receiver, 8N1 sampled mid bit
  initial begin : uart_rx
    spi_byte_t   rx_byte;
    logic [31:0] word_bits;
    int          n_bytes;
    n_bytes = 0;
    word_bits = '0;
    rx_byte = '0;
    forever begin
      @(negedge serial_out);
      repeat (BAUD_DIV / 2) @(negedge clk);
      if (serial_out !== 1'b0) begin
        note_failure("start bit on serial_out did not last to mid bit");
      end
      for (int b = 0; b < 8; b++) begin
        repeat (BAUD_DIV) @(negedge clk);
        // lsb arrives first
        rx_byte = {serial_out, rx_byte[7:1]};
      end
      repeat (BAUD_DIV) @(negedge clk);
      if (serial_out !== 1'b1) begin
        note_failure("stop bit on serial_out was low");
      end
      word_bits = {word_bits[23:0], rx_byte};
      n_bytes++;
      if (n_bytes == SAMPLE_BYTES) begin
        rx_words.push_back(sample_t'(word_bits));
        n_bytes = 0;
      end
    end
  end

  // every word against its shot, in order
  initial begin : compare
    sample_t got;
    forever begin
      @(negedge clk);
      if (rx_words.size() != 0) begin
        got = rx_words.pop_front();
        if (n_words < shot_results.size()) begin
          check_sample("serial word", got, expected_sample(n_words, shot_results[n_words]));
        end else begin
          note_failure("serial word arrived with no matching shot");
        end
        n_words++;
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d of %0d words received",
             cycles, n_words, NUM_SAMPLES);
    $display("Regression failed");
    $finish;
  end

  initial begin : main_seq
    int base_err;
    int start_mark;
    int paused_starts;
    int assert_fails;
    clk = 1'b0;
    rst_n = 1'b0;
    pause = 1'b0;
    tdc_intb = 1'b1;
    tdc_miso = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // idle pins
    @(negedge clk);
    base_err = errors;
    check_level("serial_out", serial_out, 1'b1);
    check_level("tdc_cs", tdc_cs, 1'b1);
    check_level("tdc_start_signal", tdc_start_signal, 1'b0);
    check_level("tdc_sck", tdc_sck, 1'b0);
    report_test("1 idle levels after reset", errors == base_err);

    wait_words(8);
    report_test("2 opcode on tdc_mosi", byte_errors == 0 && n_xfers >= 8);
    report_test("3 words match reference", sample_errors == 0);

    // by now the fifo has backed up
    wait_words(16);
    if (!saw_full) begin
      note_failure("fifo never filled, backlog not exercised");
    end
    report_test("4 backlog keeps order", saw_full && sample_errors == 0);

    base_err = sample_errors;
    @(posedge clk);
    #2;
    pause = 1'b1;
    // a pulse from the previous edge still counts as in progress
    @(posedge clk);
    start_mark = n_starts;
    repeat (PAUSE_CYCLES) @(posedge clk);
    paused_starts = n_starts - start_mark;
    #2;
    pause = 1'b0;
    if (paused_starts != 0) begin
      note_failure($sformatf("%0d start pulses while pause was high", paused_starts));
    end
    if (start_mark >= NUM_SAMPLES) begin
      note_failure("no shot after the pause falls inside the checked words");
    end
    wait_words(NUM_SAMPLES);
    report_test("5 pause and resume", paused_starts == 0 && sample_errors == base_err
                && start_mark < NUM_SAMPLES);

    assert_fails = DUT.tdc_shot_control.shot_props.fail_count
                 + DUT.sample_fifo.fifo_props.fail_count;
    if (assert_fails != 0) begin
      note_failure($sformatf("%0d assertion failures in the bound checkers", assert_fails));
    end
    $display("%0d checks, %0d errors, %0d words, %0d shots",
             n_checks, errors, n_words, n_starts);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
